// ==== common/aesPkg.sv ====
//********************
// AES-128 shared types
// datapath command enums and struct
// round structure constants
// GF(2^4)/GF(2^8) arithmetic
//********************
`default_nettype none

package aesPkg;

  typedef logic [127:0] aesBlock_t; // first byte in [127:120]
  typedef logic [7:0]   aesByte_t;
  typedef logic [31:0]  aesWord_t;

  typedef enum logic [2:0] {
    stHold,
    stLoad,
    stByte,      // AddRoundKey + SubBytes on outgoing byte
    stShiftRows,
    stMixCol,    // one column per step
    stFinal      // AddRoundKey only
  } stateOp_e;

  typedef enum logic [2:0] {
    kyHold,
    kyLoad,
    kyRestart,   // cipher key -> working key
    kyByte,
    kyExpand     // one row of the next round key
  } keyOp_e;

  typedef struct packed {
    stateOp_e stateOp;
    keyOp_e   keyOp;
    logic     lastRound; // no MixColumns, last rcon
  } dpCtrl_t;

  localparam int NumRounds     = 10;
  localparam int ByteSteps     = 16;
  localparam int ColSteps      = 4;
  localparam int StepsPerRound = ByteSteps + 1 + ColSteps; // 21

  // multiply by x in the AES field
  function automatic aesByte_t xtime(input aesByte_t a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  // GF(2^2), z^2 = z + 1
  function automatic logic [1:0] gf2Mul(input logic [1:0] a, input logic [1:0] b);
    logic hh;
    hh = a[1] & b[1];
    return {hh ^ (a[1] & b[0]) ^ (a[0] & b[1]), hh ^ (a[0] & b[0])};
  endfunction

  // GF((2^2)^2), y^2 = y + phi, phi = z
  function automatic logic [3:0] gf4Mul(input logic [3:0] a, input logic [3:0] b);
    logic [1:0] hh;
    logic [1:0] ll;
    hh = gf2Mul(a[3:2], b[3:2]);
    ll = gf2Mul(a[1:0], b[1:0]);
    return {gf2Mul(a[3:2] ^ a[1:0], b[3:2] ^ b[1:0]) ^ ll,
            {hh[1] ^ hh[0], hh[1]} ^ ll}; // hh * phi
  endfunction

  // lambda * q^2, lambda = 4'b1100
  function automatic logic [3:0] gf4SqScl(input logic [3:0] q);
    logic [3:0] s;
    s = {q[3], q[3] ^ q[2], q[2] ^ q[1], q[3] ^ q[1] ^ q[0]};
    return {s[2] ^ s[0], s[3] ^ s[2] ^ s[1] ^ s[0], s[3], s[2]};
  endfunction

  function automatic logic [3:0] gf4Inv(input logic [3:0] q);
    logic [3:0] x;
    x[3] = q[3] ^ (q[3] & q[2] & q[1]) ^ (q[3] & q[0]) ^ q[2];
    x[2] = (q[3] & q[2] & q[1]) ^ (q[3] & q[2] & q[0]) ^ (q[3] & q[0]) ^ q[2]
         ^ (q[2] & q[1]);
    x[1] = q[3] ^ (q[3] & q[2] & q[1]) ^ (q[3] & q[1] & q[0]) ^ q[2] ^ (q[2] & q[0])
         ^ q[1];
    x[0] = (q[3] & q[2] & q[1]) ^ (q[3] & q[2] & q[0]) ^ (q[3] & q[1])
         ^ (q[3] & q[1] & q[0]) ^ (q[3] & q[0]) ^ q[2] ^ (q[2] & q[1])
         ^ (q[2] & q[1] & q[0]) ^ q[1] ^ q[0];
    return x;
  endfunction

  // inverse in GF((2^4)^2), x^2 = x + lambda, zero maps to zero
  function automatic aesByte_t gf8Inv(input aesByte_t a);
    logic [3:0] hi;
    logic [3:0] sum;
    logic [3:0] dInv;
    hi   = a[7:4];
    sum  = a[7:4] ^ a[3:0];
    dInv = gf4Inv(gf4SqScl(hi) ^ gf4Mul(a[3:0], sum)); // norm
    return {gf4Mul(hi, dInv), gf4Mul(sum, dInv)};
  endfunction

endpackage

`default_nettype wire

// ==== control/roundCounter.sv ====
//********************
// step and round counter
//********************
`timescale 1ns/1ps
`default_nettype none

module roundCounter (
  input  wire        CLK,
  input  wire        RSTn,
  input  wire        EN,
  input  wire        cntRun,
  input  wire        cntClear,
  output logic [4:0] stepCnt,
  output logic [3:0] roundCnt
);

  always_ff @(posedge CLK) begin
    if (!RSTn) begin
      stepCnt  <= '0;
      roundCnt <= '0;
    end else if (EN) begin
      if (cntClear) begin
        stepCnt  <= '0;
        roundCnt <= '0;
      end else if (cntRun) begin
        if (stepCnt == aesPkg::StepsPerRound - 1) begin
          stepCnt  <= '0; // wrap into next round
          roundCnt <= roundCnt + 4'd1;
        end else begin
          stepCnt <= stepCnt + 5'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== control/aesControl.sv ====
//********************
// round controller FSM
// host strobes, BSY/Dvld/Kvld
// per-cycle datapath command
//********************
`timescale 1ns/1ps
`default_nettype none

module aesControl (
  input  wire        CLK,
  input  wire        RSTn,
  input  wire        EN,
  input  wire        Drdy,
  input  wire        Krdy,
  input  wire [4:0]  stepCnt,
  input  wire [3:0]  roundCnt,
  output logic       cntRun,
  output logic       cntClear,
  output aesPkg::dpCtrl_t ctrl,
  output logic       Dvld,
  output logic       Kvld,
  output logic       BSY
);

  typedef enum logic [1:0] {fsmIdle, fsmRound, fsmFinal} fsmState_e;

  fsmState_e fsmState;

  assign cntRun = (fsmState != fsmIdle);

  // command decode from registered phase and counts
  always_comb begin
    ctrl.stateOp   = aesPkg::stHold;
    ctrl.keyOp     = aesPkg::kyHold;
    ctrl.lastRound = 1'b0;
    cntClear       = 1'b0;
    case (fsmState)
      fsmIdle: begin
        if (Krdy) begin
          ctrl.keyOp = aesPkg::kyLoad; // key wins over data
        end else if (Drdy) begin
          ctrl.stateOp = aesPkg::stLoad;
          ctrl.keyOp   = aesPkg::kyRestart;
          cntClear     = 1'b1;
        end
      end
      fsmRound: begin
        ctrl.lastRound = (roundCnt == aesPkg::NumRounds - 1);
        if (stepCnt < aesPkg::ByteSteps) begin
          ctrl.stateOp = aesPkg::stByte;
          ctrl.keyOp   = aesPkg::kyByte;
        end else if (stepCnt == aesPkg::ByteSteps) begin
          ctrl.stateOp = aesPkg::stShiftRows;
        end else if (stepCnt <= aesPkg::ByteSteps + aesPkg::ColSteps) begin
          ctrl.stateOp = aesPkg::stMixCol; // key expands alongside
          ctrl.keyOp   = aesPkg::kyExpand;
        end
      end
      fsmFinal: begin
        ctrl.stateOp = aesPkg::stFinal; // last round key
        ctrl.keyOp   = aesPkg::kyByte;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RSTn) begin
      fsmState <= fsmIdle;
      BSY      <= 1'b0;
      Dvld     <= 1'b0;
      Kvld     <= 1'b0;
    end else if (EN) begin
      case (fsmState)
        fsmIdle: begin
          Dvld <= 1'b0; // one-cycle pulse
          if (Krdy) begin
            Kvld <= 1'b1;
          end else if (Drdy) begin
            fsmState <= fsmRound;
            BSY      <= 1'b1;
            Kvld     <= 1'b0;
          end
        end
        fsmRound: begin
          if (stepCnt == aesPkg::StepsPerRound - 1 && roundCnt == aesPkg::NumRounds - 1) begin
            fsmState <= fsmFinal;
          end
        end
        fsmFinal: begin
          if (stepCnt == aesPkg::ByteSteps - 1) begin
            fsmState <= fsmIdle;
            BSY      <= 1'b0;
            Dvld     <= 1'b1; // ciphertext on Dout now
          end
        end
        default: fsmState <= fsmIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== datapath/sboxUnit.sv ====
//********************
// AES S-box, composite
// field inverse + affine
//********************
`timescale 1ns/1ps
`default_nettype none

module sboxUnit (
  input  wire aesPkg::aesByte_t in,
  output aesPkg::aesByte_t      out
);

  aesPkg::aesByte_t mapped;
  aesPkg::aesByte_t inverted;
  aesPkg::aesByte_t unmapped;

  // AES field to GF((2^4)^2)
  assign mapped = {in[7] ^ in[5],
                   in[7] ^ in[6] ^ in[4] ^ in[3] ^ in[2] ^ in[1],
                   in[7] ^ in[5] ^ in[3] ^ in[2],
                   in[7] ^ in[5] ^ in[3] ^ in[2] ^ in[1],
                   in[7] ^ in[6] ^ in[2] ^ in[1],
                   in[7] ^ in[4] ^ in[3] ^ in[2] ^ in[1],
                   in[6] ^ in[4] ^ in[1],
                   in[6] ^ in[1] ^ in[0]};

  assign inverted = aesPkg::gf8Inv(mapped);

  // and back
  assign unmapped = {inverted[7] ^ inverted[6] ^ inverted[5] ^ inverted[1],
                     inverted[6] ^ inverted[2],
                     inverted[6] ^ inverted[5] ^ inverted[1],
                     inverted[6] ^ inverted[5] ^ inverted[4] ^ inverted[2] ^ inverted[1],
                     inverted[5] ^ inverted[4] ^ inverted[3] ^ inverted[2] ^ inverted[1],
                     inverted[7] ^ inverted[4] ^ inverted[3] ^ inverted[2] ^ inverted[1],
                     inverted[5] ^ inverted[4],
                     inverted[6] ^ inverted[5] ^ inverted[4] ^ inverted[2] ^ inverted[0]};

  // affine map, b ^ rotl1..4 ^ 0x63
  assign out = unmapped
             ^ {unmapped[6:0], unmapped[7]}
             ^ {unmapped[5:0], unmapped[7:6]}
             ^ {unmapped[4:0], unmapped[7:5]}
             ^ {unmapped[3:0], unmapped[7:4]}
             ^ 8'h63;

endmodule

`default_nettype wire

// ==== datapath/stateArray.sv ====
//********************
// AES state register
// byte shift, ShiftRows,
// column-serial MixColumns
//********************
`timescale 1ns/1ps
`default_nettype none

module stateArray (
  input  wire                    CLK,
  input  wire                    RSTn,
  input  wire                    EN,
  input  wire aesPkg::dpCtrl_t   ctrl,
  input  wire aesPkg::aesBlock_t Din,
  input  wire aesPkg::aesByte_t  keyByte,
  input  wire aesPkg::aesByte_t  sboxOut,
  output aesPkg::aesByte_t       sboxIn,
  output aesPkg::aesBlock_t      Dout
);

  aesPkg::aesBlock_t stateQ;
  aesPkg::aesBlock_t shifted;
  aesPkg::aesByte_t  addKey;

  // column is {row0, row1, row2, row3}, row0 on top
  function automatic aesPkg::aesWord_t mixColumn(input aesPkg::aesWord_t col);
    aesPkg::aesByte_t a [4];
    aesPkg::aesByte_t tot;
    aesPkg::aesWord_t res;
    for (int i = 0; i < 4; i++) begin
      a[i] = col[31-8*i -: 8];
    end
    tot = a[0] ^ a[1] ^ a[2] ^ a[3];
    for (int i = 0; i < 4; i++) begin
      res[31-8*i -: 8] = a[i] ^ tot ^ aesPkg::xtime(a[i] ^ a[(i+1)%4]); // 2a ^ 3b ^ c ^ d
    end
    return res;
  endfunction

  assign addKey = stateQ[127:120] ^ keyByte; // outgoing byte
  assign sboxIn = addKey;
  assign Dout   = stateQ;

  // row r rotates left by r columns
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted[127-8*(4*c+r) -: 8] = stateQ[127-8*(4*((c+r)%4)+r) -: 8];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RSTn) begin
      stateQ <= '0;
    end else if (EN) begin
      case (ctrl.stateOp)
        aesPkg::stLoad:      stateQ <= Din;
        aesPkg::stByte:      stateQ <= {stateQ[119:0], sboxOut};
        aesPkg::stShiftRows: stateQ <= shifted;
        aesPkg::stMixCol: begin
          if (!ctrl.lastRound) begin
            stateQ <= {stateQ[95:0], mixColumn(stateQ[127:96])}; // rotate columns
          end
        end
        aesPkg::stFinal:     stateQ <= {stateQ[119:0], addKey};
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== datapath/keyArray.sv ====
//********************
// cipher key and round key
// row-serial key expansion
//********************
`timescale 1ns/1ps
`default_nettype none

module keyArray (
  input  wire                    CLK,
  input  wire                    RSTn,
  input  wire                    EN,
  input  wire aesPkg::dpCtrl_t   ctrl,
  input  wire aesPkg::aesBlock_t Kin,
  input  wire aesPkg::aesByte_t  sboxOut,
  output aesPkg::aesByte_t       sboxIn,
  output aesPkg::aesByte_t       keyByte
);

  aesPkg::aesBlock_t cipherKey;
  aesPkg::aesBlock_t workKey;
  aesPkg::aesBlock_t expanded;
  aesPkg::aesByte_t  rcon;
  logic [1:0]        rowIdx;     // row being expanded
  aesPkg::aesByte_t  rowNew [4];

  assign keyByte = workKey[127:120];

  // RotWord: row below the active one in the last column.
  // On the last row that byte was already rewritten, so undo w3' = w3 ^ w2'
  assign sboxIn = workKey[23:16] ^ ((rowIdx == 2'd3) ? workKey[55:48] : 8'h00);

  // columns shift up by one byte, new row enters at the bottom
  always_comb begin
    rowNew[0] = workKey[127:120] ^ sboxOut ^ ((rowIdx == 2'd0) ? rcon : 8'h00);
    for (int c = 1; c < 4; c++) begin
      rowNew[c] = workKey[127-32*c -: 8] ^ rowNew[c-1]; // w[c] ^= w[c-1]
    end
    for (int c = 0; c < 4; c++) begin
      expanded[127-32*c -: 32] = {workKey[119-32*c -: 24], rowNew[c]};
    end
  end

  always_ff @(posedge CLK) begin
    if (!RSTn) begin
      cipherKey <= '0;
      workKey   <= '0;
      rcon      <= '0;
      rowIdx    <= '0;
    end else if (EN) begin
      case (ctrl.keyOp)
        aesPkg::kyLoad: cipherKey <= Kin;
        aesPkg::kyRestart: begin
          workKey <= cipherKey;
          rcon    <= 8'h01;
          rowIdx  <= '0;
        end
        aesPkg::kyByte: workKey <= {workKey[119:0], workKey[127:120]}; // track state bytes
        aesPkg::kyExpand: begin
          workKey <= expanded;
          rowIdx  <= rowIdx + 2'd1;
          if (rowIdx == 2'd3) begin
            rcon <= aesPkg::xtime(rcon); // next round
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/aesCore.sv ====
//********************
// AES-128 core top
// byte-serial encryption
//********************
`timescale 1ns/1ps
`default_nettype none

module aesCore (
  input  wire                CLK,
  input  wire                RSTn,
  input  wire                EN,
  input  wire                Drdy,
  input  wire                Krdy,
  input  wire aesPkg::aesBlock_t Din,
  input  wire aesPkg::aesBlock_t Kin,
  output aesPkg::aesBlock_t  Dout,
  output logic               Dvld,
  output logic               Kvld,
  output logic               BSY
);

  aesPkg::dpCtrl_t  ctrl;
  logic [4:0]       stepCnt;
  logic [3:0]       roundCnt;
  logic             cntRun;
  logic             cntClear;
  aesPkg::aesByte_t stSboxIn;
  aesPkg::aesByte_t stSboxOut;
  aesPkg::aesByte_t kySboxIn;
  aesPkg::aesByte_t kySboxOut;
  aesPkg::aesByte_t keyByte;

  aesControl i_aesControl (
    .CLK(CLK), .RSTn(RSTn), .EN(EN), .Drdy(Drdy), .Krdy(Krdy),
    .stepCnt(stepCnt), .roundCnt(roundCnt), .cntRun(cntRun), .cntClear(cntClear),
    .ctrl(ctrl), .Dvld(Dvld), .Kvld(Kvld), .BSY(BSY)
  );

  roundCounter i_roundCounter (
    .CLK(CLK), .RSTn(RSTn), .EN(EN), .cntRun(cntRun), .cntClear(cntClear),
    .stepCnt(stepCnt), .roundCnt(roundCnt)
  );

  stateArray i_stateArray (
    .CLK(CLK), .RSTn(RSTn), .EN(EN), .ctrl(ctrl), .Din(Din), .keyByte(keyByte),
    .sboxOut(stSboxOut), .sboxIn(stSboxIn), .Dout(Dout)
  );

  keyArray i_keyArray (
    .CLK(CLK), .RSTn(RSTn), .EN(EN), .ctrl(ctrl), .Kin(Kin),
    .sboxOut(kySboxOut), .sboxIn(kySboxIn), .keyByte(keyByte)
  );

  sboxUnit i_stateSbox (.in(stSboxIn), .out(stSboxOut)); // SubBytes
  sboxUnit i_keySbox (.in(kySboxIn), .out(kySboxOut));   // SubWord

endmodule

`default_nettype wire

// ==== verif/aesCore_chk.sv ====
//********************
// host strobe assertions
//********************
`timescale 1ns/1ps
`default_nettype none

module aesCore_chk (
  input wire CLK,
  input wire RSTn,
  input wire EN,
  input wire Drdy,
  input wire Krdy,
  input wire Dvld,
  input wire Kvld,
  input wire BSY
);

  int violations = 0; // read by the testbench at the end

  dvldPulse: assert property (@(posedge CLK) disable iff (!RSTn) Dvld && EN |=> !Dvld)
    else begin
      $error("Dvld stayed high for more than one enabled cycle");
      violations++;
    end

  dvldNotBusy: assert property (@(posedge CLK) disable iff (!RSTn) !(Dvld && BSY))
    else begin
      $error("Dvld and BSY high together");
      violations++;
    end

  busyNoKey: assert property (@(posedge CLK) disable iff (!RSTn) !(BSY && Kvld))
    else begin
      $error("BSY and Kvld high together");
      violations++;
    end

  // accepted only from idle, and Krdy wins
  busyStart: assert property (@(posedge CLK) disable iff (!RSTn)
      $rose(BSY) |-> $past(Drdy && !Krdy && !BSY && EN))
    else begin
      $error("BSY rose without an accepted Drdy");
      violations++;
    end

endmodule

`default_nettype wire

// ==== verif/aesModel.svh ====
//********************
// FIPS-197 AES-128 model
// S-box table, encryption
//********************
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

logic [7:0] sboxTab [256];

function automatic logic [7:0] mulX(input logic [7:0] a);
  return (a << 1) ^ (a[7] ? 8'h1b : 8'h00);
endfunction

// inverse through log/antilog tables of generator 3, then the affine map
function automatic void buildSbox();
  logic [7:0] expT [256];
  logic [7:0] logT [256];
  logic [7:0] p;
  logic [7:0] inv;
  p = 8'h01;
  for (int i = 0; i < 255; i++) begin
    expT[i] = p;
    logT[p] = 8'(i);
    p = p ^ mulX(p); // times 3
  end
  for (int x = 0; x < 256; x++) begin
    if (x == 0) begin
      inv = 8'h00;
    end else begin
      inv = expT[(255 - logT[x]) % 255];
    end
    sboxTab[x] = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
               ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  end
endfunction

// state byte i is row i%4 of column i/4
function automatic logic [127:0] aesEncrypt(input logic [127:0] key, input logic [127:0] pt);
  logic [7:0] s [16];
  logic [7:0] t [16];
  logic [7:0] k [16];
  logic [7:0] sw [4];
  logic [7:0] rc;
  logic [127:0] ct;
  rc = 8'h01;
  for (int i = 0; i < 16; i++) begin
    k[i] = key[127-8*i -: 8];
    s[i] = pt[127-8*i -: 8] ^ k[i];
  end
  for (int rnd = 1; rnd <= 10; rnd++) begin
    for (int i = 0; i < 16; i++) begin
      t[i] = sboxTab[s[i]];
    end
    for (int i = 0; i < 16; i++) begin
      s[i] = t[4*((i/4 + i%4) % 4) + i%4]; // ShiftRows
    end
    if (rnd < 10) begin
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
          t[r] = s[4*c+r];
        end
        for (int r = 0; r < 4; r++) begin
          s[4*c+r] = mulX(t[r]) ^ mulX(t[(r+1)%4]) ^ t[(r+1)%4] ^ t[(r+2)%4] ^ t[(r+3)%4];
        end
      end
    end
    for (int r = 0; r < 4; r++) begin
      sw[r] = sboxTab[k[12 + (r+1)%4]]; // SubWord(RotWord(w3))
    end
    sw[0] = sw[0] ^ rc;
    for (int i = 0; i < 4; i++) begin
      k[i] = k[i] ^ sw[i];
    end
    for (int i = 4; i < 16; i++) begin
      k[i] = k[i] ^ k[i-4];
    end
    rc = mulX(rc);
    for (int i = 0; i < 16; i++) begin
      s[i] = s[i] ^ k[i];
    end
  end
  for (int i = 0; i < 16; i++) begin
    ct[127-8*i -: 8] = s[i];
  end
  return ct;
endfunction

`endif

// ==== verif/aesCoreTb.sv ====
//********************
// AES-128 core testbench
// random blocks and keys vs model
// busy noise, EN stalls, output hold
//********************
`timescale 1ns/1ps
`default_nettype none

module aesCoreTb;

  localparam int Seed      = 85174;
  localparam int EncCycles = 226;
  localparam int WaitLimit = 2000; // cycles per encryption
  localparam logic [127:0] KatKey    = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [127:0] KatPlain  = 128'h00112233445566778899aabbccddeeff;
  localparam logic [127:0] KatCipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  logic CLK;
  logic RSTn;
  logic EN;
  logic Drdy;
  logic Krdy;
  aesPkg::aesBlock_t Din;
  aesPkg::aesBlock_t Kin;
  aesPkg::aesBlock_t Dout;
  logic Dvld;
  logic Kvld;
  logic BSY;

  aesPkg::aesBlock_t curKey;
  string testName;
  int errCnt = 0;
  int testErr = 0;
  int testCnt = 0;
  int failCnt = 0;

  `include "aesModel.svh"

  aesCore i_aesCore (.*);

  bind aesCore aesCore_chk i_aesCoreChk (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic aesPkg::aesBlock_t randomBlock();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic checkBlock(input string what, input logic [127:0] exp, input logic [127:0] act);
    assert (act === exp) else begin
      $display("Fail %s %s: expected %h, actual %h", testName, what, exp, act);
      errCnt++;
    end
  endtask

  task automatic checkCount(input string what, input int exp, input int act);
    assert (act == exp) else begin
      $display("Fail %s %s: expected %0d, actual %0d", testName, what, exp, act);
      errCnt++;
    end
  endtask

  task automatic startTest(input string name);
    testName = name;
    testErr  = errCnt;
  endtask

  task automatic endTest();
    testCnt++;
    if (errCnt == testErr) begin
      $display("test %s: ok", testName);
    end else begin
      failCnt++;
      $display("test %s: failed with %0d errors", testName, errCnt - testErr);
    end
  endtask

  // called on a falling edge
  task automatic loadKey(input aesPkg::aesBlock_t key);
    Kin  = key;
    Krdy = 1'b1;
    EN   = 1'b1;
    @(negedge CLK);
    Krdy   = 1'b0;
    curKey = key;
    checkCount("Kvld after key load", 1, Kvld);
  endtask

  task automatic encryptBlock(input aesPkg::aesBlock_t block, input bit noise, input bit stall);
    aesPkg::aesBlock_t expected;
    int cycles;
    int lowCycles;
    expected  = aesEncrypt(curKey, block);
    cycles    = 0;
    lowCycles = 0;
    Din  = block;
    Drdy = 1'b1;
    EN   = 1'b1;
    @(negedge CLK);
    Drdy = 1'b0;
    checkCount("BSY after accept", 1, BSY);
    checkCount("Kvld after accept", 0, Kvld);
    while (!Dvld && cycles <= WaitLimit) begin
      EN = !stall || ($urandom_range(3) != 0);
      if (noise) begin
        Drdy = 1'($urandom); // ignored while busy
        Krdy = 1'($urandom);
        Din  = randomBlock();
        Kin  = randomBlock();
      end
      @(negedge CLK);
      cycles++;
      if (!EN) begin
        lowCycles++;
      end
    end
    EN   = 1'b1;
    Drdy = 1'b0;
    Krdy = 1'b0;
    if (!Dvld) begin
      $display("timeout: no Dvld within %0d cycles in test %s", WaitLimit, testName);
      $display("STATUS: FAIL");
      $finish;
    end else begin
      checkCount("latency", EncCycles + lowCycles, cycles);
      checkBlock("Dout", expected, Dout);
    end
  endtask

  // idle cycles with noise on data and key inputs
  task automatic holdOutput(input aesPkg::aesBlock_t cipher);
    int idle;
    idle = $urandom_range(12, 3);
    for (int i = 0; i < idle; i++) begin
      Din = randomBlock();
      Kin = randomBlock();
      EN  = 1'($urandom);
      @(negedge CLK);
      checkBlock("Dout hold", cipher, Dout);
    end
    EN = 1'b1;
  endtask

  initial begin
    aesPkg::aesBlock_t blk;
    RSTn = 1'b0;
    EN   = 1'b0;
    Drdy = 1'b0;
    Krdy = 1'b0;
    Din  = '0;
    Kin  = '0;
    void'($urandom(Seed));
    buildSbox();
    repeat (4) @(negedge CLK);
    RSTn = 1'b1;
    EN   = 1'b1;
    @(negedge CLK);

    startTest("reset");
    checkCount("BSY", 0, BSY);
    checkCount("Dvld", 0, Dvld);
    checkCount("Kvld", 0, Kvld);
    checkBlock("Dout", '0, Dout);
    endTest();

    startTest("knownAnswer");
    checkBlock("model", KatCipher, aesEncrypt(KatKey, KatPlain));
    loadKey(KatKey);
    encryptBlock(KatPlain, 1'b0, 1'b0);
    endTest();

    startTest("keyLoad");
    loadKey(randomBlock()); // Kvld falls inside encryptBlock
    encryptBlock(randomBlock(), 1'b0, 1'b0);
    endTest();

    startTest("randomEncrypt");
    for (int k = 0; k < 5; k++) begin
      loadKey(randomBlock());
      for (int b = 0; b < 8; b++) begin
        encryptBlock(randomBlock(), 1'b0, 1'b0);
      end
    end
    endTest();

    startTest("busyNoise");
    for (int b = 0; b < 6; b++) begin
      encryptBlock(randomBlock(), 1'b1, 1'b0); // stored key reused every block
    end
    endTest();

    startTest("enStall");
    for (int b = 0; b < 6; b++) begin
      encryptBlock(randomBlock(), 1'b1, 1'b1);
    end
    endTest();

    startTest("outputHold");
    for (int b = 0; b < 4; b++) begin
      blk = randomBlock();
      encryptBlock(blk, 1'b0, 1'b0);
      holdOutput(aesEncrypt(curKey, blk));
    end
    endTest();

    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             testCnt, failCnt, errCnt, i_aesCore.i_aesCoreChk.violations);
    if (failCnt == 0 && i_aesCore.i_aesCoreChk.violations == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verif
common/aesPkg.sv
control/roundCounter.sv
control/aesControl.sv
datapath/sboxUnit.sv
datapath/stateArray.sv
datapath/keyArray.sv
hdl/aesCore.sv
verif/aesCore_chk.sv
verif/aesCoreTb.sv

// ==== Bender.yml ====
package:
  name: aes_core

sources:
  - common/aesPkg.sv
  - control/roundCounter.sv
  - control/aesControl.sv
  - datapath/sboxUnit.sv
  - datapath/stateArray.sv
  - datapath/keyArray.sv
  - hdl/aesCore.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/aesCore_chk.sv
      - verif/aesCoreTb.sv
